// File: design/agc_pkg.sv
package agc_pkg;

    // memory cycle timing
    localparam int TP_DIV   = 25;               // sys_clk cycles per timepulse
    localparam int TP_CNT_W = $clog2(TP_DIV);

    // rope image geometry
    localparam int ROPE_ADDR_W = 4;             // 16 words, wraps after word 15

    // EPCS serial flash
    localparam int          EPCS_CMD_W      = 8;
    localparam int          EPCS_ADDR_W     = 24;
    localparam logic [7:0]  EPCS_READ_CMD   = 8'h03;
    localparam logic [23:0] ROPE_BASE       = 24'h000100;

    // command, address and one data word per frame
    localparam int EPCS_FRAME_BITS = 48;
    localparam int EPCS_BIT_CNT_W  = $clog2(EPCS_FRAME_BITS);

    // one field per sequential memory-cycle pulse, mt01 is the msb
    typedef struct packed {
        logic mt01;
        logic mt02;
        logic mt03;
        logic mt04;
        logic mt05;
        logic mt06;
        logic mt07;
        logic mt08;
        logic mt09;
        logic mt10;
        logic mt11;
        logic mt12;
    } timepulse_t;

    // word as stored in flash, msb first
    typedef struct packed {
        logic [14:0] data;
        logic        parity;    // odd parity over the whole word
    } rope_word_t;

    typedef logic [ROPE_ADDR_W-1:0] rope_addr_t;

endpackage

// File: design/agc_timepulse_gen.sv
`timescale 1ns/10ps

module agc_timepulse_gen import agc_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    output timepulse_t mt
);

    logic [TP_CNT_W-1:0] tp_cnt;
    logic                tick;
    logic [11:0]         ring;

    // clock enable divider, one tick every TP_DIV cycles
    assign tick = (tp_cnt == TP_CNT_W'(TP_DIV - 1));

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            tp_cnt <= '0;
        end else if (tick) begin
            tp_cnt <= '0;
        end else begin
            tp_cnt <= tp_cnt + 1'b1;
        end
    end

    // one-hot ring, bit 11 is mt01 and bit 0 is mt12
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            ring <= '0;                            // all pulses low until first tick
        end else if (tick) begin
            if (ring == '0) begin
                ring <= 12'b1000_0000_0000;        // first tick raises mt01
            end else begin
                ring <= {ring[0], ring[11:1]};     // mt12 wraps back to mt01
            end
        end
    end

    assign mt = timepulse_t'(ring);

endmodule

// File: design/epcs_word_reader.sv
`timescale 1ns/10ps

module epcs_word_reader import agc_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       fetch_req,
    input  rope_addr_t fetch_addr,
    output logic       fetch_done,
    output rope_word_t fetch_word,
    input  logic       epcs_data,
    output logic       epcs_csn,
    output logic       epcs_dclk,
    output logic       epcs_asdi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,
        ST_FINISH
    } rd_state_t;

    rd_state_t                             state;
    logic [EPCS_BIT_CNT_W-1:0]             bit_cnt;
    logic [EPCS_CMD_W+EPCS_ADDR_W-1:0]     tx_sreg;
    logic [$bits(rope_word_t)-1:0]         rx_sreg;
    logic [EPCS_ADDR_W-1:0]                byte_addr;

    // two bytes per rope word
    assign byte_addr = ROPE_BASE + EPCS_ADDR_W'({fetch_addr, 1'b0});

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            bit_cnt    <= '0;
            tx_sreg    <= '0;
            epcs_csn   <= 1'b1;
            epcs_dclk  <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    epcs_dclk <= 1'b0;
                    if (fetch_req) begin
                        tx_sreg  <= {EPCS_READ_CMD, byte_addr};
                        bit_cnt  <= '0;
                        epcs_csn <= 1'b0;
                        state    <= ST_SHIFT;
                    end
                end

                ST_SHIFT: begin
                    if (!epcs_dclk) begin
                        epcs_dclk <= 1'b1;                  // rising edge
                    end else begin
                        epcs_dclk <= 1'b0;                  // falling edge, next bit out
                        tx_sreg   <= {tx_sreg[$bits(tx_sreg)-2:0], 1'b0};
                        if (bit_cnt == EPCS_BIT_CNT_W'(EPCS_FRAME_BITS - 1)) begin
                            state <= ST_FINISH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end

                ST_FINISH: begin
                    epcs_csn   <= 1'b1;
                    fetch_done <= 1'b1;
                    state      <= ST_IDLE;
                end

                default: begin
                    epcs_csn <= 1'b1;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    // sample flash output on the edge that raises dclk
    // data was set up by the flash at the previous falling edge
    always_ff @(posedge sys_clk) begin
        if (state == ST_SHIFT && !epcs_dclk) begin
            rx_sreg <= {rx_sreg[$bits(rx_sreg)-2:0], epcs_data};
        end
    end

    // last 16 samples of the frame are the data word
    assign fetch_word = rope_word_t'(rx_sreg);
    assign epcs_asdi  = tx_sreg[$bits(tx_sreg)-1];

endmodule

// File: design/rope_sequencer.sv
`timescale 1ns/10ps

module rope_sequencer import agc_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       key0,
    input  timepulse_t mt,
    output logic       fetch_req,
    output rope_addr_t fetch_addr,
    input  logic       fetch_done,
    input  rope_word_t fetch_word,
    output rope_word_t word,
    output logic       word_valid,
    output logic       parity_alarm
);

    logic       key_meta;
    logic       key_sync;
    logic       armed;
    logic       mt01_d;
    logic       mt01_rise;
    rope_addr_t addr_cnt;

    // key0 is active low and asynchronous to sys_clk
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            key_meta <= 1'b1;
            key_sync <= 1'b1;
        end else begin
            key_meta <= key0;
            key_sync <= key_meta;
        end
    end

    // stays armed until reset once the key was seen pressed
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (!key_sync) begin
            armed <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mt01_d <= 1'b0;
        end else begin
            mt01_d <= mt.mt01;
        end
    end

    assign mt01_rise = mt.mt01 & ~mt01_d;
    assign fetch_req = armed & mt01_rise;   // one fetch per memory cycle

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            addr_cnt <= '0;
        end else if (fetch_req) begin
            addr_cnt <= addr_cnt + 1'b1;     // wraps after word 15
        end
    end

    assign fetch_addr = addr_cnt;

    // returned word, presented one cycle after fetch_done
    always_ff @(posedge sys_clk) begin
        if (fetch_done) begin
            word <= fetch_word;
        end
    end

    // good word has an odd count of ones over all 16 bits
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            word_valid   <= 1'b0;
            parity_alarm <= 1'b0;
        end else begin
            word_valid   <= fetch_done;
            parity_alarm <= fetch_done & ~(^fetch_word);
        end
    end

endmodule

// File: design/de0_nano_agc.sv
`timescale 1ns/10ps

module de0_nano_agc import agc_pkg::*; (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic       key0,
    input  logic       epcs_data,
    output logic       epcs_csn,
    output logic       epcs_dclk,
    output logic       epcs_asdi,
    output timepulse_t mt,
    output rope_word_t word,
    output logic       word_valid,
    output logic       parity_alarm
);

    // strobes between sequencer and flash reader
    logic       fetch_req;
    rope_addr_t fetch_addr;
    logic       fetch_done;
    rope_word_t fetch_word;

    agc_timepulse_gen i_agc_timepulse_gen (
        .sys_clk (sys_clk),
        .rst_n   (rst_n),
        .mt      (mt)
    );

    epcs_word_reader i_epcs_word_reader (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_done (fetch_done),
        .fetch_word (fetch_word),
        .epcs_data  (epcs_data),
        .epcs_csn   (epcs_csn),
        .epcs_dclk  (epcs_dclk),
        .epcs_asdi  (epcs_asdi)
    );

    rope_sequencer i_rope_sequencer (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .key0         (key0),
        .mt           (mt),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_done   (fetch_done),
        .fetch_word   (fetch_word),
        .word         (word),
        .word_valid   (word_valid),
        .parity_alarm (parity_alarm)
    );

endmodule

// File: tests/epcs_flash_model.sv
`timescale 1ns/10ps

module epcs_flash_model import agc_pkg::*; (
    input  logic epcs_csn,
    input  logic epcs_dclk,
    input  logic epcs_asdi,
    output logic epcs_data
);

    localparam int HDR_BITS    = EPCS_CMD_W + EPCS_ADDR_W;
    localparam int IMAGE_BYTES = 2 * (1 << ROPE_ADDR_W);

    int          bit_cnt = 0;
    int          frames = 0;
    int          frame_errors = 0;
    logic        in_frame = 1'b0;
    logic [31:0] shift_in = '0;
    logic [31:0] hdr;
    logic [15:0] out_word = '0;
    logic        data_q = 1'b0;

    function automatic logic [15:0] image_word(input int w);
        logic [14:0] data;
        data = 15'((w * 'h2B5 + 'h11) % 32768);
        return {data, ((w % 7) == 3) ? ^data : ~^data};
    endfunction

    // high byte at the even address
    function automatic logic [7:0] image_byte(input logic [23:0] byte_addr);
        logic [15:0] w;
        w = image_word(int'((byte_addr - ROPE_BASE) >> 1));
        return byte_addr[0] ? w[7:0] : w[15:8];
    endfunction

    always @(posedge epcs_dclk or posedge epcs_csn) begin
        if (epcs_csn) begin
            if (in_frame) begin
                frames++;
                if (bit_cnt != EPCS_FRAME_BITS) begin
                    frame_errors++;
                    $display("flash model: frame of %0d bits ended at %0t", bit_cnt, $time);
                end
            end
            in_frame = 1'b0;
            bit_cnt  = 0;
        end else begin
            in_frame = 1'b1;
            shift_in = {shift_in[30:0], epcs_asdi};
            bit_cnt++;
            if (bit_cnt == HDR_BITS) begin
                hdr = shift_in;
                if (hdr[31:24] != EPCS_READ_CMD) begin
                    frame_errors++;
                    $display("flash model: unsupported opcode %h at %0t", hdr[31:24], $time);
                end
                if (hdr[23:0] < ROPE_BASE || hdr[23:0] >= ROPE_BASE + IMAGE_BYTES - 1) begin
                    frame_errors++;
                    out_word = '0;
                    $display("flash model: address %h outside the image", hdr[23:0]);
                end else begin
                    out_word = {image_byte(hdr[23:0]), image_byte(hdr[23:0] + 1'b1)};
                end
            end
        end
    end

    // data bits change on the falling edge, msb first
    always @(negedge epcs_dclk) begin
        if (!epcs_csn && bit_cnt >= HDR_BITS && bit_cnt < EPCS_FRAME_BITS) begin
            data_q <= out_word[EPCS_FRAME_BITS - 1 - bit_cnt];
        end
    end

    assign epcs_data = data_q;

endmodule

// File: tests/de0_nano_agc_checker.sv
`timescale 1ns/10ps

module de0_nano_agc_checker import agc_pkg::*; (
    input logic       sys_clk,
    input logic       rst_n,
    input timepulse_t mt,
    input logic       epcs_csn,
    input logic       epcs_dclk,
    input logic       word_valid
);

    int assert_errors = 0;

    // at most one timepulse, none before the first tick
    mt_onehot: assert property (@(posedge sys_clk) disable iff (!rst_n) $onehot0(mt))
        else begin
            $error("mt is not one-hot: %b", mt);
            assert_errors++;
        end

    dclk_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
                                epcs_csn |-> !epcs_dclk)
        else begin
            $error("epcs_dclk high while epcs_csn is high");
            assert_errors++;
        end

    valid_after_read: assert property (@(posedge sys_clk) disable iff (!rst_n)
                                       word_valid |-> epcs_csn)
        else begin
            $error("word_valid while a flash read is running");
            assert_errors++;
        end

endmodule

bind de0_nano_agc de0_nano_agc_checker i_de0_nano_agc_checker (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .mt         (mt),
    .epcs_csn   (epcs_csn),
    .epcs_dclk  (epcs_dclk),
    .word_valid (word_valid)
);

// File: tests/tb_de0_nano_agc.sv
`timescale 1ns/10ps

module tb_de0_nano_agc import agc_pkg::*; ();

    localparam time CLK_PERIOD   = 40ns;
    localparam int  RESET_CYCLES = 4;
    localparam int  MEM_CYCLE    = 12 * TP_DIV;       // sys_clk cycles per memory cycle
    localparam int  WORDS        = 1 << ROPE_ADDR_W;
    localparam int  WRAP_WORDS   = 4;

    logic       sys_clk = 1'b0;
    logic       rst_n;
    logic       key0;
    logic       epcs_data;
    logic       epcs_csn;
    logic       epcs_dclk;
    logic       epcs_asdi;
    timepulse_t mt;
    rope_word_t word;
    logic       word_valid;
    logic       parity_alarm;

    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;
    int          release_cyc;
    int          first_mt01_cyc;
    int          key_delay;
    logic        key_delay_ready = 1'b0;
    logic [31:0] lfsr = 32'h38c9;
    logic        got_alarm [WORDS];

    de0_nano_agc i_de0_nano_agc (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .key0         (key0),
        .epcs_data    (epcs_data),
        .epcs_csn     (epcs_csn),
        .epcs_dclk    (epcs_dclk),
        .epcs_asdi    (epcs_asdi),
        .mt           (mt),
        .word         (word),
        .word_valid   (word_valid),
        .parity_alarm (parity_alarm)
    );

    epcs_flash_model i_epcs_flash_model (
        .epcs_csn  (epcs_csn),
        .epcs_dclk (epcs_dclk),
        .epcs_asdi (epcs_asdi),
        .epcs_data (epcs_data)
    );

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    always @(posedge sys_clk) cyc <= cyc + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic rope_word_t expected_word(input int w);
        rope_word_t exp;
        exp.data   = 15'((w * 'h2B5 + 'h11) % (1 << 15));
        exp.parity = ~^exp.data;               // odd count of ones over the word
        if (w % 7 == 3) begin
            exp.parity = ~exp.parity;          // words planted with bad parity
        end
        return exp;
    endfunction

    task automatic compare_word(input rope_word_t got, input rope_word_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, expected %h/%b got %h/%b", $time, msg,
                     exp.data, exp.parity, got.data, got.parity);
        end
    endtask

    task automatic compare_timepulse(input timepulse_t got, input timepulse_t exp,
                                     input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, expected %b got %b", $time, msg, exp, got);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, expected %b got %b", $time, msg, exp, got);
        end
    endtask

    task automatic next_cycle();
        @(posedge sys_clk);
        #2ns;
    endtask

    task automatic reset_state();
        rst_n = 1'b0;
        key0  = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
            compare_timepulse(mt, '0, "mt during reset");
            compare_bit(epcs_csn, 1'b1, "epcs_csn during reset");
            compare_bit(epcs_dclk, 1'b0, "epcs_dclk during reset");
            compare_bit(word_valid, 1'b0, "word_valid during reset");
            compare_bit(parity_alarm, 1'b0, "parity_alarm during reset");
        end
        rst_n       = 1'b1;
        release_cyc = cyc;
        while (mt == '0 && cyc - release_cyc < 2 * TP_DIV) begin
            next_cycle();
            compare_bit(word_valid, 1'b0, "word_valid before key0");
            compare_bit(epcs_csn, 1'b1, "flash access before key0");
        end
        first_mt01_cyc = cyc;
    endtask

    task automatic timepulse_ring();
        timepulse_t exp;
        compare_bit(logic'(first_mt01_cyc - release_cyc == TP_DIV), 1'b1,
                    $sformatf("first mt01 after %0d cycles", first_mt01_cyc - release_cyc));
        for (int p = 0; p < 24; p++) begin
            exp = timepulse_t'(12'b1000_0000_0000 >> (p % 12));   // mt01 first
            for (int c = 0; c < TP_DIV; c++) begin
                compare_timepulse(mt, exp, $sformatf("pulse %0d cycle %0d", p, c));
                compare_bit(word_valid, 1'b0, "word_valid before key0");
                next_cycle();
            end
        end
    endtask

    // waits for the next memory cycle and returns the word fetched in it
    task automatic collect_word(output rope_word_t w, output logic alarm);
        int   n;
        logic mt01_prev;
        n = 0;
        do begin
            mt01_prev = mt.mt01;
            next_cycle();
            n++;
            compare_bit(word_valid, 1'b0, "word_valid outside its memory cycle");
            compare_bit(parity_alarm, 1'b0, "parity_alarm outside its memory cycle");
        end while (!(mt.mt01 && !mt01_prev) && n <= MEM_CYCLE);
        n = 0;
        while (!word_valid && n < MEM_CYCLE - 1) begin
            compare_bit(parity_alarm, 1'b0, "parity_alarm without word_valid");
            next_cycle();
            n++;
        end
        w     = word;
        alarm = parity_alarm;
        if (!word_valid) begin
            errors++;
            $display("no word arrived before mt12 ended, memory cycle ending at %0t", $time);
        end
    endtask

    task automatic word_sequence();
        rope_word_t w;
        logic       alarm;
        repeat (key_delay) next_cycle();
        key0 = 1'b0;
        repeat (4) next_cycle();
        key0 = 1'b1;                            // sequencer stays armed after release
        for (int i = 0; i < WORDS; i++) begin
            collect_word(w, alarm);
            compare_word(w, expected_word(i), $sformatf("word %0d", i));
            got_alarm[i] = alarm;
        end
    endtask

    task automatic parity_alarm_check();
        for (int i = 0; i < WORDS; i++) begin
            compare_bit(got_alarm[i], logic'(i % 7 == 3),
                        $sformatf("parity_alarm for word %0d", i));
        end
    endtask

    task automatic address_wrap();
        rope_word_t w;
        logic       alarm;
        for (int i = 0; i < WRAP_WORDS; i++) begin
            collect_word(w, alarm);
            compare_word(w, expected_word(i), $sformatf("word %0d after wrap", i));
            compare_bit(alarm, logic'(i % 7 == 3),
                        $sformatf("parity_alarm for word %0d after wrap", i));
        end
    endtask

    task automatic flash_frame();
        next_cycle();
        compare_bit(logic'(i_epcs_flash_model.frame_errors == 0), 1'b1,
                    $sformatf("%0d malformed flash frames", i_epcs_flash_model.frame_errors));
        compare_bit(logic'(i_epcs_flash_model.frames == WORDS + WRAP_WORDS), 1'b1,
                    $sformatf("%0d flash frames seen", i_epcs_flash_model.frames));
        compare_bit(logic'(i_de0_nano_agc.i_de0_nano_agc_checker.assert_errors == 0), 1'b1,
                    "assertion failures in the checker");
    endtask

    initial begin
        rst_n = 1'b0;
        key0  = 1'b1;
        draw_bits(8, key_delay);
        key_delay_ready = 1'b1;
        reset_state();
        timepulse_ring();
        word_sequence();
        parity_alarm_check();
        address_wrap();
        flash_frame();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // whole run fits in 24 memory cycles plus reset and key delay
    initial begin
        wait (key_delay_ready);
        #((24 * MEM_CYCLE + RESET_CYCLES + key_delay) * CLK_PERIOD);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
design/agc_pkg.sv
design/agc_timepulse_gen.sv
design/epcs_word_reader.sv
design/rope_sequencer.sv
design/de0_nano_agc.sv
tests/epcs_flash_model.sv
tests/de0_nano_agc_checker.sv
tests/tb_de0_nano_agc.sv

// File: Bender.yml
package:
  name: de0_nano_agc

dependencies: {}

sources:
  - files:
      - design/agc_pkg.sv
      - design/agc_timepulse_gen.sv
      - design/epcs_word_reader.sv
      - design/rope_sequencer.sv
      - design/de0_nano_agc.sv
  - target: test
    files:
      - tests/epcs_flash_model.sv
      - tests/de0_nano_agc_checker.sv
      - tests/tb_de0_nano_agc.sv
